// ==== verilog/hello_params.svh ====
/*
 * hello-world register map constants
 * register addresses, the value returned for unmapped reads
 * and the AXI-Lite response code used on both channels
 */

`ifndef HELLO_PARAMS_SVH
`define HELLO_PARAMS_SVH

// byte-swapped on readback
`define HELLO_WORLD_REG_ADDR 32'h0000_0500

// led shadow, low 16 bits only
`define VLED_REG_ADDR 32'h0000_0504

// anything outside the map reads as this
`define UNIMPLEMENTED_REG_VALUE 32'hDEAD_DEAD

// only response this slave ever gives
`define RESP_OKAY 2'b00

`endif

// ==== verilog/axil_pkg.sv ====
/*
 * AXI-Lite bus types
 * address, data and response widths of the slave port,
 * plus the states of the write channel FSM
 */

package axil_pkg;

   // byte address from the master
   typedef logic [31:0] addr_t;

   // single data beat, no strobes
   typedef logic [31:0] data_t;

   // bresp / rresp code
   typedef logic [1:0] resp_t;

   // write channel FSM
   // idle waits for AW, data waits for W, resp holds B
   typedef enum logic [1:0] {
      WR_IDLE = 2'd0,
      WR_DATA = 2'd1,
      WR_RESP = 2'd2
   } wr_state_e;

endpackage

// ==== verilog/hello_pkg.sv ====
/*
 * hello-world register map types
 * contents of the hello-world word and the
 * width of the virtual LED and DIP vectors
 */

package hello_pkg;

   // full hello-world register
   typedef logic [31:0] hello_word_t;

   // one bit per virtual LED or DIP switch
   typedef logic [15:0] vled_t;

endpackage

// ==== verilog/axil_write_slave.sv ====
/*
 * AXI-Lite write slave
 * takes one AW beat, then one W beat, then holds an OKAY
 * B response until the master accepts it; the W transfer
 * becomes a single-cycle write strobe to the register file
 */

`timescale 1ns/10ps

`include "hello_params.svh"

module axil_write_slave (
   input  logic                     clk_main_a0,
   input  logic                     rst_main_n_sync,
   input  logic                     i_awvalid,
   input  axil_pkg::addr_t          i_awaddr,
   output logic                     o_awready,
   input  logic                     i_wvalid,
   input  axil_pkg::data_t          i_wdata,
   output logic                     o_wready,
   output logic                     o_bvalid,
   output axil_pkg::resp_t          o_bresp,
   input  logic                     i_bready,
   output logic                     o_wr_en,
   output axil_pkg::addr_t          o_wr_addr,
   output axil_pkg::data_t          o_wr_data
);

   axil_pkg::wr_state_e wr_state;
   axil_pkg::wr_state_e wr_state_nxt;
   axil_pkg::addr_t     wr_addr_q;

   // ---------------------------------------------------------------------
   // state machine
   // ---------------------------------------------------------------------
   always_comb
   begin
      wr_state_nxt = wr_state;
      case (wr_state)
         axil_pkg::WR_IDLE:
            if (i_awvalid)
               wr_state_nxt = axil_pkg::WR_DATA;
         axil_pkg::WR_DATA:
            // wready follows wvalid, so valid alone is the transfer
            if (i_wvalid)
               wr_state_nxt = axil_pkg::WR_RESP;
         axil_pkg::WR_RESP:
            if (i_bready)
               wr_state_nxt = axil_pkg::WR_IDLE;
         default:
            wr_state_nxt = axil_pkg::WR_IDLE;
      endcase
   end

   always_ff @(posedge clk_main_a0)
   begin
      if (!rst_main_n_sync)
      begin
         wr_state  <= axil_pkg::WR_IDLE;
         wr_addr_q <= '0;
      end
      else
      begin
         wr_state <= wr_state_nxt;
         // address held for the data beat
         if (wr_state == axil_pkg::WR_IDLE && i_awvalid)
            wr_addr_q <= i_awaddr;
      end
   end

   // ---------------------------------------------------------------------
   // channel outputs
   // ---------------------------------------------------------------------
   assign o_awready = (wr_state == axil_pkg::WR_IDLE);
   assign o_wready  = (wr_state == axil_pkg::WR_DATA) && i_wvalid;
   assign o_bvalid  = (wr_state == axil_pkg::WR_RESP);
   assign o_bresp   = `RESP_OKAY;

   // write strobe on the W transfer edge, data straight from the bus
   assign o_wr_en   = o_wready;
   assign o_wr_addr = wr_addr_q;
   assign o_wr_data = i_wdata;

   // response must not be withdrawn before the master takes it
   bvalid_held_a : assert property (
      @(posedge clk_main_a0) disable iff (!rst_main_n_sync)
      (o_bvalid && !i_bready) |=> o_bvalid
   );

endmodule

// ==== verilog/axil_read_slave.sv ====
/*
 * AXI-Lite read slave
 * captures the read address on a completed AR handshake,
 * strobes the register file one cycle later, registers the
 * returned word and holds R until the master accepts it
 */

`timescale 1ns/10ps

`include "hello_params.svh"

module axil_read_slave (
   input  logic                     clk_main_a0,
   input  logic                     rst_main_n_sync,
   input  logic                     i_arvalid,
   input  axil_pkg::addr_t          i_araddr,
   output logic                     o_arready,
   output logic                     o_rvalid,
   output axil_pkg::data_t          o_rdata,
   output axil_pkg::resp_t          o_rresp,
   input  logic                     i_rready,
   output logic                     o_rd_en,
   output axil_pkg::addr_t          o_rd_addr,
   input  axil_pkg::data_t          i_rd_data
);

   logic            rd_pend_q;
   axil_pkg::addr_t rd_addr_q;
   logic            rvalid_q;
   axil_pkg::data_t rdata_q;

   // one access at a time
   assign o_arready = !rd_pend_q && !rvalid_q;

   // ---------------------------------------------------------------------
   // address capture, only on a real handshake
   // ---------------------------------------------------------------------
   always_ff @(posedge clk_main_a0)
   begin
      if (!rst_main_n_sync)
      begin
         rd_pend_q <= 1'b0;
         rd_addr_q <= '0;
      end
      else if (i_arvalid && o_arready)
      begin
         rd_pend_q <= 1'b1;
         rd_addr_q <= i_araddr;
      end
      else
      begin
         rd_pend_q <= 1'b0;
      end
   end

   // lookup strobe, one cycle after AR
   assign o_rd_en   = rd_pend_q;
   assign o_rd_addr = rd_addr_q;

   // ---------------------------------------------------------------------
   // read data hold
   // ---------------------------------------------------------------------
   always_ff @(posedge clk_main_a0)
   begin
      if (!rst_main_n_sync)
      begin
         rvalid_q <= 1'b0;
         rdata_q  <= '0;
      end
      else if (o_rd_en)
      begin
         rvalid_q <= 1'b1;
         rdata_q  <= i_rd_data;
      end
      else if (rvalid_q && i_rready)
      begin
         rvalid_q <= 1'b0;
      end
   end

   assign o_rvalid = rvalid_q;
   assign o_rdata  = rdata_q;
   assign o_rresp  = `RESP_OKAY;

   // data frozen while the master stalls
   rdata_stable_a : assert property (
      @(posedge clk_main_a0) disable iff (!rst_main_n_sync)
      (o_rvalid && !i_rready) |=> $stable(o_rdata)
   );

endmodule

// ==== verilog/hello_regs.sv ====
/*
 * hello-world register file
 * stores the word written to the hello-world address and
 * decodes reads: swapped word, LED shadow or a fixed
 * marker for addresses outside the map
 */

`timescale 1ns/10ps

`include "hello_params.svh"

module hello_regs (
   input  logic                     clk_main_a0,
   input  logic                     rst_main_n_sync,
   input  logic                     i_wr_en,
   input  axil_pkg::addr_t          i_wr_addr,
   input  axil_pkg::data_t          i_wr_data,
   input  axil_pkg::addr_t          i_rd_addr,
   output axil_pkg::data_t          o_rd_data,
   input  hello_pkg::vled_t         i_vled,
   output hello_pkg::hello_word_t   o_hello
);

   hello_pkg::hello_word_t hello_q;
   hello_pkg::hello_word_t hello_swapped;

   // ---------------------------------------------------------------------
   // write decode
   // ---------------------------------------------------------------------
   always_ff @(posedge clk_main_a0)
   begin
      if (!rst_main_n_sync)
         hello_q <= '0;
      // writes to other addresses are accepted and dropped
      else if (i_wr_en && (i_wr_addr == `HELLO_WORLD_REG_ADDR))
         hello_q <= i_wr_data;
   end

   assign o_hello = hello_q;

   // byte order reversed on readback
   assign hello_swapped = {hello_q[7:0], hello_q[15:8], hello_q[23:16], hello_q[31:24]};

   // ---------------------------------------------------------------------
   // read mux
   // ---------------------------------------------------------------------
   always_comb
   begin
      case (i_rd_addr)
         `HELLO_WORLD_REG_ADDR:
            o_rd_data = hello_swapped;
         `VLED_REG_ADDR:
            // zero-extended, not swapped
            o_rd_data = {16'h0000, i_vled};
         default:
            o_rd_data = `UNIMPLEMENTED_REG_VALUE;
      endcase
   end

endmodule

// ==== verilog/vled_ctrl.sv ====
/*
 * virtual LED control
 * shadows the low half of the hello-world word, brings the
 * DIP switches in through two flops and drives the LED
 * shadow masked by the switches
 */

`timescale 1ns/10ps

module vled_ctrl (
   input  logic                     clk_main_a0,
   input  logic                     rst_main_n_sync,
   input  hello_pkg::hello_word_t   i_hello,
   input  hello_pkg::vled_t         i_status_vdip,
   output hello_pkg::vled_t         o_vled,
   output hello_pkg::vled_t         o_status_vled
);

   hello_pkg::vled_t vdip_q;
   hello_pkg::vled_t vdip_q2;
   hello_pkg::vled_t vled_q;
   hello_pkg::vled_t status_vled_q;

   // ---------------------------------------------------------------------
   // sync, shadow and masked output
   // ---------------------------------------------------------------------
   always_ff @(posedge clk_main_a0)
   begin
      if (!rst_main_n_sync)
      begin
         vdip_q        <= '0;
         vdip_q2       <= '0;
         vled_q        <= '0;
         status_vled_q <= '0;
      end
      else
      begin
         // two-flop synchronizer for the switches
         vdip_q        <= i_status_vdip;
         vdip_q2       <= vdip_q;
         // led shadow lags the register by one edge
         vled_q        <= i_hello[15:0];
         // switch low turns its led off
         status_vled_q <= vled_q & vdip_q2;
      end
   end

   assign o_vled        = vled_q;
   assign o_status_vled = status_vled_q;

endmodule

// ==== verilog/cl_hello_world.sv ====
/*
 * hello-world custom logic top
 * AXI-Lite slave port split into write and read channel
 * blocks, feeding the hello-world register file and the
 * virtual LED logic
 */

`timescale 1ns/10ps

module cl_hello_world (
   input  logic                     clk_main_a0,
   input  logic                     rst_main_n_sync,
   input  logic                     i_awvalid,
   input  axil_pkg::addr_t          i_awaddr,
   output logic                     o_awready,
   input  logic                     i_wvalid,
   input  axil_pkg::data_t          i_wdata,
   output logic                     o_wready,
   output logic                     o_bvalid,
   output axil_pkg::resp_t          o_bresp,
   input  logic                     i_bready,
   input  logic                     i_arvalid,
   input  axil_pkg::addr_t          i_araddr,
   output logic                     o_arready,
   output logic                     o_rvalid,
   output axil_pkg::data_t          o_rdata,
   output axil_pkg::resp_t          o_rresp,
   input  logic                     i_rready,
   input  hello_pkg::vled_t         i_status_vdip,
   output hello_pkg::vled_t         o_status_vled
);

   // register write port
   logic                   wr_en;
   axil_pkg::addr_t        wr_addr;
   axil_pkg::data_t        wr_data;
   // register read port
   axil_pkg::addr_t        rd_addr;
   axil_pkg::data_t        rd_data;
   // register file <-> led logic
   hello_pkg::hello_word_t hello;
   hello_pkg::vled_t       vled;

   // ---------------------------------------------------------------------
   // AXI-Lite channels
   // ---------------------------------------------------------------------
   axil_write_slave write_slave_i (
      .clk_main_a0     (clk_main_a0),
      .rst_main_n_sync (rst_main_n_sync),
      .i_awvalid       (i_awvalid),
      .i_awaddr        (i_awaddr),
      .o_awready       (o_awready),
      .i_wvalid        (i_wvalid),
      .i_wdata         (i_wdata),
      .o_wready        (o_wready),
      .o_bvalid        (o_bvalid),
      .o_bresp         (o_bresp),
      .i_bready        (i_bready),
      .o_wr_en         (wr_en),
      .o_wr_addr       (wr_addr),
      .o_wr_data       (wr_data)
   );

   axil_read_slave read_slave_i (
      .clk_main_a0     (clk_main_a0),
      .rst_main_n_sync (rst_main_n_sync),
      .i_arvalid       (i_arvalid),
      .i_araddr        (i_araddr),
      .o_arready       (o_arready),
      .o_rvalid        (o_rvalid),
      .o_rdata         (o_rdata),
      .o_rresp         (o_rresp),
      .i_rready        (i_rready),
      // no read side effects in this register map
      .o_rd_en         (),
      .o_rd_addr       (rd_addr),
      .i_rd_data       (rd_data)
   );

   // ---------------------------------------------------------------------
   // registers and leds
   // ---------------------------------------------------------------------
   hello_regs regs_i (
      .clk_main_a0     (clk_main_a0),
      .rst_main_n_sync (rst_main_n_sync),
      .i_wr_en         (wr_en),
      .i_wr_addr       (wr_addr),
      .i_wr_data       (wr_data),
      .i_rd_addr       (rd_addr),
      .o_rd_data       (rd_data),
      .i_vled          (vled),
      .o_hello         (hello)
   );

   vled_ctrl vled_i (
      .clk_main_a0     (clk_main_a0),
      .rst_main_n_sync (rst_main_n_sync),
      .i_hello         (hello),
      .i_status_vdip   (i_status_vdip),
      .o_vled          (vled),
      .o_status_vled   (o_status_vled)
   );

endmodule

// ==== test/tb_clock_gen.sv ====
/*
 * testbench clock and reset
 * free-running 100 ns clock, reset held low for
 * ten cycles and released just after an edge
 */

`timescale 1ns/10ps

module tb_clock_gen (
   output logic clk_main_a0,
   output logic rst_main_n_sync
);

   localparam int HALF_PERIOD_NS = 50;
   localparam int RESET_CYCLES   = 10;
   localparam int RELEASE_NS     = 10;

   initial
   begin
      clk_main_a0 = 1'b0;
      forever #HALF_PERIOD_NS clk_main_a0 = ~clk_main_a0;
   end

   // release lines up with the stimulus slot
   initial
   begin
      rst_main_n_sync = 1'b0;
      repeat (RESET_CYCLES) @(posedge clk_main_a0);
      #RELEASE_NS;
      rst_main_n_sync = 1'b1;
   end

endmodule

// ==== test/tb_hello_world.sv ====
/*
 * hello-world register block testbench
 * directed tests over the AXI-Lite port: reset state, byte
 * swap, unmapped addresses, LED shadow, DIP masking and
 * back-pressure on B and R
 */

`timescale 1ns/10ps

`include "hello_params.svh"

module tb_hello_world;

   localparam int NUM_TESTS  = 6;
   localparam int CYCLE_NS   = 100;
   localparam int DRIVE_NS   = 10;
   localparam int SWAP_WORDS = 8;

   logic                   clk_main_a0;
   logic                   rst_main_n_sync;
   logic                   awvalid;
   axil_pkg::addr_t        awaddr;
   logic                   awready;
   logic                   wvalid;
   axil_pkg::data_t        wdata;
   logic                   wready;
   logic                   bvalid;
   axil_pkg::resp_t        bresp;
   logic                   bready;
   logic                   arvalid;
   axil_pkg::addr_t        araddr;
   logic                   arready;
   logic                   rvalid;
   axil_pkg::data_t        rdata;
   axil_pkg::resp_t        rresp;
   logic                   rready;
   hello_pkg::vled_t       vdip;
   hello_pkg::vled_t       vled;

   int                     errors;
   int                     checks;
   int                     tests_run;
   logic [31:0]            rng_state;
   // last word written to the hello-world register
   hello_pkg::hello_word_t hello_model;

   tb_clock_gen clock_gen_i (
      .clk_main_a0     (clk_main_a0),
      .rst_main_n_sync (rst_main_n_sync)
   );

   cl_hello_world dut_i (
      .clk_main_a0     (clk_main_a0),
      .rst_main_n_sync (rst_main_n_sync),
      .i_awvalid       (awvalid),
      .i_awaddr        (awaddr),
      .o_awready       (awready),
      .i_wvalid        (wvalid),
      .i_wdata         (wdata),
      .o_wready        (wready),
      .o_bvalid        (bvalid),
      .o_bresp         (bresp),
      .i_bready        (bready),
      .i_arvalid       (arvalid),
      .i_araddr        (araddr),
      .o_arready       (arready),
      .o_rvalid        (rvalid),
      .o_rdata         (rdata),
      .o_rresp         (rresp),
      .i_rready        (rready),
      .i_status_vdip   (vdip),
      .o_status_vled   (vled)
   );

   // ---------------------------------------------------------------------
   // helpers
   // ---------------------------------------------------------------------
   function automatic logic [31:0] xorshift32(input logic [31:0] x);
      logic [31:0] s;
      s = x ^ (x << 13);
      s = s ^ (s >> 17);
      s = s ^ (s << 5);
      return s;
   endfunction

   function automatic logic [31:0] next_random();
      rng_state = xorshift32(rng_state);
      return rng_state;
   endfunction

   // byte 0 ends up in the top lane
   function automatic logic [31:0] reverse_bytes(input logic [31:0] w);
      logic [31:0] r;
      for (int i = 0; i < 4; i++)
         r[8*i +: 8] = w[8*(3-i) +: 8];
      return r;
   endfunction

   // one clock, then into the drive slot
   task automatic step();
      @(posedge clk_main_a0);
      #DRIVE_NS;
   endtask

   task automatic check_value(input string name, input logic [31:0] got,
                              input logic [31:0] exp);
      checks++;
      assert (got === exp)
      else
      begin
         $display("mismatch %s: got %08h, expected %08h", name, got, exp);
         errors++;
      end
   endtask

   task automatic check_bit(input string name, input logic got, input logic exp);
      checks++;
      assert (got === exp)
      else
      begin
         $display("mismatch %s: got %h, expected %h", name, got, exp);
         errors++;
      end
   endtask

   task automatic finish_test(input string name, input int errors_before);
      tests_run++;
      if (errors == errors_before)
         $display("test %0d %s: ok", tests_run, name);
      else
         $display("test %0d %s: %0d failing check(s)", tests_run, name, errors - errors_before);
   endtask

   // ---------------------------------------------------------------------
   // AXI-Lite master
   // ---------------------------------------------------------------------
   // stall holds bready low for that many cycles once bvalid is up
   task automatic axil_write(input axil_pkg::addr_t addr, input axil_pkg::data_t data,
                             input int stall, output axil_pkg::resp_t resp);
      awvalid = 1'b1;
      awaddr  = addr;
      while (!awready)
         step();
      step();
      awvalid = 1'b0;
      wvalid  = 1'b1;
      wdata   = data;
      // wready follows wvalid, so look at it mid-cycle
      @(negedge clk_main_a0);
      while (!wready)
         @(negedge clk_main_a0);
      step();
      wvalid = 1'b0;
      while (!bvalid)
         step();
      repeat (stall)
      begin
         check_bit("awready during B stall", awready, 1'b0);
         step();
         check_bit("bvalid during B stall", bvalid, 1'b1);
      end
      resp   = bresp;
      bready = 1'b1;
      step();
      bready = 1'b0;
   endtask

   task automatic axil_read(input axil_pkg::addr_t addr, input int stall,
                            output axil_pkg::data_t data, output axil_pkg::resp_t resp);
      axil_pkg::data_t held;
      arvalid = 1'b1;
      araddr  = addr;
      while (!arready)
         step();
      step();
      arvalid = 1'b0;
      while (!rvalid)
         step();
      held = rdata;
      repeat (stall)
      begin
         check_bit("arready during R stall", arready, 1'b0);
         step();
         check_bit("rvalid during R stall", rvalid, 1'b1);
         check_value("rdata during R stall", rdata, held);
      end
      data   = rdata;
      resp   = rresp;
      rready = 1'b1;
      step();
      rready = 1'b0;
   endtask

   // ---------------------------------------------------------------------
   // directed tests
   // ---------------------------------------------------------------------
   task automatic test_reset_state();
      int              e0;
      axil_pkg::data_t d;
      axil_pkg::resp_t r;
      e0 = errors;
      check_bit("o_awready", awready, 1'b1);
      check_bit("o_arready", arready, 1'b1);
      check_bit("o_bvalid", bvalid, 1'b0);
      check_bit("o_rvalid", rvalid, 1'b0);
      check_value("o_status_vled", 32'(vled), 32'h0);
      axil_read(`HELLO_WORLD_REG_ADDR, 0, d, r);
      check_value("o_rdata hello", d, 32'h0);
      finish_test("reset state", e0);
   endtask

   task automatic test_byte_swap();
      int              e0;
      axil_pkg::data_t w;
      axil_pkg::data_t d;
      axil_pkg::resp_t r;
      e0 = errors;
      repeat (SWAP_WORDS)
      begin
         w = next_random();
         axil_write(`HELLO_WORLD_REG_ADDR, w, 0, r);
         check_value("o_bresp", 32'(r), 32'(`RESP_OKAY));
         hello_model = w;
         axil_read(`HELLO_WORLD_REG_ADDR, 0, d, r);
         check_value("o_rdata hello", d, reverse_bytes(w));
         check_value("o_rresp", 32'(r), 32'(`RESP_OKAY));
      end
      finish_test("byte swap", e0);
   endtask

   task automatic test_unmapped();
      int              e0;
      axil_pkg::addr_t a;
      axil_pkg::data_t d;
      axil_pkg::resp_t r;
      e0 = errors;
      // neighbours of the map plus one random address
      a = next_random();
      if (a == `HELLO_WORLD_REG_ADDR || a == `VLED_REG_ADDR)
         a = a ^ 32'h0000_1000;
      axil_read(32'h0000_0000, 0, d, r);
      check_value("o_rdata addr 0000", d, `UNIMPLEMENTED_REG_VALUE);
      axil_read(32'h0000_04fc, 0, d, r);
      check_value("o_rdata addr 04fc", d, `UNIMPLEMENTED_REG_VALUE);
      axil_read(32'h0000_0501, 0, d, r);
      check_value("o_rdata addr 0501", d, `UNIMPLEMENTED_REG_VALUE);
      axil_read(32'h0000_0508, 0, d, r);
      check_value("o_rdata addr 0508", d, `UNIMPLEMENTED_REG_VALUE);
      axil_read(a, 0, d, r);
      check_value("o_rdata random addr", d, `UNIMPLEMENTED_REG_VALUE);
      check_value("o_rresp", 32'(r), 32'(`RESP_OKAY));
      // write elsewhere must leave the register alone
      axil_write(32'h0000_0600, next_random(), 0, r);
      check_value("o_bresp", 32'(r), 32'(`RESP_OKAY));
      axil_read(`HELLO_WORLD_REG_ADDR, 0, d, r);
      check_value("o_rdata hello", d, reverse_bytes(hello_model));
      finish_test("unmapped addresses", e0);
   endtask

   task automatic test_led_shadow();
      int              e0;
      axil_pkg::data_t w;
      axil_pkg::data_t d;
      axil_pkg::resp_t r;
      e0 = errors;
      w = next_random();
      axil_write(`HELLO_WORLD_REG_ADDR, w, 0, r);
      hello_model = w;
      axil_read(`VLED_REG_ADDR, 0, d, r);
      check_value("o_rdata vled", d, {16'h0000, w[15:0]});
      finish_test("led shadow", e0);
   endtask

   task automatic test_dip_mask();
      int               e0;
      hello_pkg::vled_t pat [3];
      e0 = errors;
      pat[0] = 16'hffff;
      pat[1] = 16'ha5c3;
      pat[2] = 16'h0000;
      for (int i = 0; i < 3; i++)
      begin
         vdip = pat[i];
         // two sync flops, then the output register
         repeat (3)
            step();
         check_value("o_status_vled", 32'(vled), 32'(hello_model[15:0] & pat[i]));
      end
      finish_test("dip masking", e0);
   endtask

   task automatic test_back_pressure();
      int              e0;
      axil_pkg::data_t w;
      axil_pkg::data_t d;
      axil_pkg::resp_t r;
      e0 = errors;
      w = next_random();
      axil_write(`HELLO_WORLD_REG_ADDR, w, 5, r);
      check_value("o_bresp", 32'(r), 32'(`RESP_OKAY));
      hello_model = w;
      axil_read(`HELLO_WORLD_REG_ADDR, 5, d, r);
      check_value("o_rdata hello", d, reverse_bytes(w));
      check_value("o_rresp", 32'(r), 32'(`RESP_OKAY));
      axil_read(`VLED_REG_ADDR, 3, d, r);
      check_value("o_rdata vled", d, {16'h0000, w[15:0]});
      finish_test("back-pressure", e0);
   endtask

   // ---------------------------------------------------------------------
   // sequence and watchdog
   // ---------------------------------------------------------------------
   initial
   begin
      awvalid     = 1'b0;
      awaddr      = '0;
      wvalid      = 1'b0;
      wdata       = '0;
      bready      = 1'b0;
      arvalid     = 1'b0;
      araddr      = '0;
      rready      = 1'b0;
      vdip        = '0;
      errors      = 0;
      checks      = 0;
      tests_run   = 0;
      rng_state   = 32'h6257_6152;
      hello_model = '0;
      @(posedge rst_main_n_sync);
      test_reset_state();
      test_byte_swap();
      test_unmapped();
      test_led_shadow();
      test_dip_mask();
      test_back_pressure();
      $display("tests %0d, checks %0d, failing checks %0d", tests_run, checks, errors);
      if (errors == 0)
         $display("Done: no errors");
      else
         $display("Done: errors found");
      $finish;
   end

   // roughly 200 cycles per test is far beyond any single test
   initial
   begin
      #(NUM_TESTS * 200 * CYCLE_NS);
      $display("watchdog expired after %0d cycles, tests did not finish", NUM_TESTS * 200);
      $display("Done: errors found");
      $finish;
   end

endmodule

// ==== src.f ====
+incdir+verilog
verilog/axil_pkg.sv
verilog/hello_pkg.sv
verilog/axil_write_slave.sv
verilog/axil_read_slave.sv
verilog/hello_regs.sv
verilog/vled_ctrl.sv
verilog/cl_hello_world.sv
test/tb_clock_gen.sv
test/tb_hello_world.sv

// ==== Makefile ====
# Verilator build and run for the hello-world register block

TOP = tb_hello_world
LOG = sim.log

.PHONY: all run lint clean

all: run

obj_dir/sim: src.f $(wildcard verilog/*.sv verilog/*.svh test/*.sv)
	verilator --binary --timing --assert -f src.f --top-module $(TOP) --Mdir obj_dir -o sim

run: obj_dir/sim
	./obj_dir/sim > $(LOG) 2>&1; cat $(LOG)
	@if grep -q "Done: errors found" $(LOG); then echo "simulation reported failure"; exit 1; fi
	@grep -q "Done: no errors" $(LOG) || { echo "simulation did not complete"; exit 1; }

lint:
	verilator --lint-only -Wall --timing -f src.f --top-module $(TOP)

clean:
	rm -rf obj_dir $(LOG)
